/* cmd_pkg.sv */
package cmd_pkg;

	// command ids as they appear in the first byte of a message
	typedef enum logic [4:0] {
		CMD_GET_VERSION        = 5'd0,
		CMD_GET_TIME           = 5'd2,
		CMD_SET_DIGITAL_OUT    = 5'd15,
		CMD_CONFIG_DIGITAL_OUT = 5'd16,
		CMD_SHUTDOWN           = 5'd19
	} cmd_e;

	// first byte of every response
	typedef enum logic [7:0] {
		RSP_GET_VERSION = 8'd0,
		RSP_GET_TIME    = 8'd1
	} rsp_e;

	typedef enum logic [1:0] {
		UNIT_NONE,
		UNIT_SYSTEM,
		UNIT_GPIO
	} unit_e;

	localparam int MAX_ARGS = 4;          // argument store depth
	localparam int ARG_IDX_BITS = 2;
	localparam int MAX_PARAMS = 4;        // response parameter store depth
	localparam int VLQ_MAX_BYTES = 5;     // 5 x 7 bits covers a 32 bit word
	localparam int CREDIT_BITS = 4;

	typedef logic signed [31:0] arg_t;

endpackage

/* unit_bus_if.sv */
`timescale 1ns/1ps

interface unit_bus_if import cmd_pkg::*; ();

	cmd_e cmd;
	logic cmd_ready;       // arg_data holds argument 0 here
	arg_t arg_data;
	logic arg_advance;     // next argument shows one cycle later
	logic cmd_done;        // param_data carries the response id
	arg_t param_data;
	logic param_write;

	modport seq (
		output cmd, cmd_ready, arg_data,
		input arg_advance, cmd_done, param_data, param_write
	);

	modport unit (
		input cmd, cmd_ready, arg_data,
		output arg_advance, cmd_done, param_data, param_write
	);

endinterface

/* vlq_decoder.sv */
`timescale 1ns/1ps

module vlq_decoder import cmd_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [7:0] msg_data,
	input logic msg_ready,
	output logic msg_rd_en,
	input logic parse_start,
	input logic [2:0] nargs,
	output logic parse_done,
	input logic [ARG_IDX_BITS-1:0] arg_idx,
	output arg_t arg_word
);

	arg_t args [MAX_ARGS];
	logic parsing;
	logic first;                       // next byte starts a new argument
	logic [2:0] cnt;                   // completed arguments
	logic [2:0] nargs_q;
	logic take;
	logic [ARG_IDX_BITS-1:0] wr_idx;
	arg_t next_val;

	// a byte is consumed only when the previous read has settled in the queue
	assign take = parsing && msg_ready && !msg_rd_en;
	assign wr_idx = cnt[ARG_IDX_BITS-1:0];
	assign arg_word = args[arg_idx];

	always_comb begin
		if (first) begin
			// bits 6:5 both set mark a negative value
			next_val = {{25{msg_data[6] & msg_data[5]}}, msg_data[6:0]};
		end else begin
			next_val = {args[wr_idx][24:0], msg_data[6:0]};
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			args[wr_idx] <= next_val;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			parsing <= 1'b0;
			first <= 1'b1;
			cnt <= '0;
			nargs_q <= '0;
			msg_rd_en <= 1'b0;
			parse_done <= 1'b0;
		end else begin
			msg_rd_en <= 1'b0;
			parse_done <= 1'b0;
			if (parse_start && !parsing) begin
				nargs_q <= nargs;
				cnt <= '0;
				first <= 1'b1;
				if (nargs == 3'd0) begin
					parse_done <= 1'b1;     // nothing to read
				end else begin
					parsing <= 1'b1;
				end
			end else if (take) begin
				msg_rd_en <= 1'b1;
				if (msg_data[7]) begin
					first <= 1'b0;
				end else begin
					first <= 1'b1;
					cnt <= cnt + 3'd1;
					if (cnt + 3'd1 == nargs_q) begin
						parsing <= 1'b0;
						parse_done <= 1'b1;
					end
				end
			end
		end
	end

	// a new command must not start while the previous arguments are still coming in
	a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
		parse_start |-> !parsing);

endmodule

/* cmd_sequencer.sv */
`timescale 1ns/1ps

module cmd_sequencer import cmd_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [7:0] msg_data,
	input logic msg_ready,
	output logic cmd_rd_en,
	output logic parse_start,
	output logic [2:0] nargs,
	input logic parse_done,
	output logic [ARG_IDX_BITS-1:0] arg_idx,
	input arg_t arg_word,
	unit_bus_if.seq sys_bus,
	unit_bus_if.seq gpio_bus,
	output logic param_push,
	output logic id_push,
	output arg_t push_data,
	output logic flush,
	input logic enc_busy
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_PARSE,
		S_DISPATCH,
		S_WAIT_DONE,
		S_EMIT,
		S_WAIT_ENC
	} state_e;

	typedef struct packed {
		unit_e unit;
		logic [2:0] nargs;
		logic has_rsp;
	} cmd_entry_t;

	state_e state;
	cmd_e cur_cmd;
	unit_e cur_unit;
	logic has_rsp;
	cmd_entry_t entry;
	logic sel_adv;
	logic sel_done;
	logic sel_pw;
	arg_t sel_pd;

	function automatic cmd_entry_t lookup(input logic [7:0] id);
		cmd_entry_t e;
		e = '{UNIT_NONE, 3'd0, 1'b0};
		if (id[7:5] == 3'd0) begin
			case (cmd_e'(id[4:0]))
			CMD_GET_VERSION:        e = '{UNIT_SYSTEM, 3'd0, 1'b1};
			CMD_GET_TIME:           e = '{UNIT_SYSTEM, 3'd0, 1'b1};
			CMD_SET_DIGITAL_OUT:    e = '{UNIT_GPIO, 3'd2, 1'b0};
			CMD_CONFIG_DIGITAL_OUT: e = '{UNIT_GPIO, 3'd3, 1'b0};
			CMD_SHUTDOWN:           e = '{UNIT_SYSTEM, 3'd0, 1'b0};
			default:                e = '{UNIT_NONE, 3'd0, 1'b0};
			endcase
		end
		return e;
	endfunction

	assign entry = lookup(msg_data);

	assign sys_bus.cmd = cur_cmd;
	assign gpio_bus.cmd = cur_cmd;
	assign sys_bus.arg_data = arg_word;    // store is read at arg_idx
	assign gpio_bus.arg_data = arg_word;

	always_comb begin
		if (cur_unit == UNIT_SYSTEM) begin
			sel_adv = sys_bus.arg_advance;
			sel_done = sys_bus.cmd_done;
			sel_pw = sys_bus.param_write;
			sel_pd = sys_bus.param_data;
		end else begin
			sel_adv = gpio_bus.arg_advance;
			sel_done = gpio_bus.cmd_done;
			sel_pw = gpio_bus.param_write;
			sel_pd = gpio_bus.param_data;
		end
	end

	always_ff @(posedge clk) begin
		if (sel_pw || sel_done) begin
			push_data <= sel_pd;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			cur_cmd <= CMD_GET_VERSION;
			cur_unit <= UNIT_NONE;
			has_rsp <= 1'b0;
			cmd_rd_en <= 1'b0;
			parse_start <= 1'b0;
			nargs <= '0;
			arg_idx <= '0;
			sys_bus.cmd_ready <= 1'b0;
			gpio_bus.cmd_ready <= 1'b0;
			param_push <= 1'b0;
			id_push <= 1'b0;
			flush <= 1'b0;
		end else begin
			cmd_rd_en <= 1'b0;
			parse_start <= 1'b0;
			sys_bus.cmd_ready <= 1'b0;
			gpio_bus.cmd_ready <= 1'b0;
			param_push <= 1'b0;
			id_push <= 1'b0;
			flush <= 1'b0;
			case (state)
			S_IDLE: begin
				if (msg_ready && !cmd_rd_en && !enc_busy) begin
					cmd_rd_en <= 1'b1;
					parse_start <= 1'b1;
					nargs <= entry.nargs;
					cur_cmd <= cmd_e'(msg_data[4:0]);
					cur_unit <= entry.unit;
					has_rsp <= entry.has_rsp;
					arg_idx <= '0;
					state <= S_PARSE;
				end
			end
			S_PARSE: begin
				if (parse_done) begin
					if (cur_unit == UNIT_NONE) begin
						state <= S_IDLE;    // unknown id is dropped
					end else begin
						sys_bus.cmd_ready <= (cur_unit == UNIT_SYSTEM);
						gpio_bus.cmd_ready <= (cur_unit == UNIT_GPIO);
						state <= S_DISPATCH;
					end
				end
			end
			S_DISPATCH, S_WAIT_DONE: begin
				state <= S_WAIT_DONE;
				if (sel_adv) begin
					arg_idx <= arg_idx + 1'b1;
				end
				if (sel_pw) begin
					param_push <= 1'b1;
				end
				if (sel_done) begin
					id_push <= has_rsp;
					state <= has_rsp ? S_EMIT : S_IDLE;
				end
			end
			S_EMIT: begin
				flush <= 1'b1;
				state <= S_WAIT_ENC;
			end
			S_WAIT_ENC: begin
				// busy rises one cycle after flush
				if (!flush && !enc_busy) begin
					state <= S_IDLE;
				end
			end
			default: state <= S_IDLE;
			endcase
		end
	end

	// a unit only finishes a command that was handed to it
	a_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		(sys_bus.cmd_done || gpio_bus.cmd_done)
		|-> (state == S_DISPATCH || state == S_WAIT_DONE));

endmodule

/* vlq_encoder.sv */
`timescale 1ns/1ps

module vlq_encoder import cmd_pkg::*; #(
	parameter int SEND_CREDITS = 4
) (
	input logic clk,
	input logic rst_n,
	input logic param_push,
	input logic id_push,
	input arg_t push_data,
	input logic flush,
	output logic busy,
	output logic [7:0] rsp_byte,
	output logic rsp_valid,
	input logic rsp_credit,
	output logic [7:0] rsp_len,
	output logic rsp_len_valid
);

	localparam int PIDX_BITS = $clog2(MAX_PARAMS);
	localparam int EXT_BITS = VLQ_MAX_BYTES * 7;

	typedef enum logic [1:0] {
		E_IDLE,
		E_ID,
		E_PARAM,
		E_LEN
	} enc_state_e;

	enc_state_e state;
	arg_t params [MAX_PARAMS];
	logic [PIDX_BITS:0] nparams;
	logic [PIDX_BITS-1:0] pidx;
	logic [2:0] grp;                   // 7 bit group still to send
	logic [7:0] len;
	logic [7:0] rsp_id;
	logic [CREDIT_BITS-1:0] credits;
	logic send_ok;
	logic take_param;
	logic last_param;
	arg_t cur_val;
	logic [EXT_BITS-1:0] cur_ext;

	// shortest encoding, leading groups that only repeat the sign are dropped
	function automatic logic [2:0] vlq_len(input arg_t v);
		if (v >= -32 && v < 96) return 3'd1;
		if (v >= -4096 && v < 12288) return 3'd2;
		if (v >= -524288 && v < 1572864) return 3'd3;
		if (v >= -67108864 && v < 201326592) return 3'd4;
		return 3'(VLQ_MAX_BYTES);
	endfunction

	assign busy = (state != E_IDLE);
	assign send_ok = (state == E_ID || state == E_PARAM) && credits != '0;
	assign take_param = (state == E_IDLE) && param_push && nparams < MAX_PARAMS;
	assign last_param = ({1'b0, pidx} + 1'b1 == nparams);
	assign cur_val = params[pidx];
	assign cur_ext = {{(EXT_BITS - 32){cur_val[31]}}, cur_val};

	always_ff @(posedge clk) begin
		if (take_param) begin
			params[nparams[PIDX_BITS-1:0]] <= push_data;
		end
		if (id_push) begin
			rsp_id <= push_data[7:0];
		end
		if (send_ok) begin
			if (state == E_ID) begin
				rsp_byte <= rsp_id;
			end else begin
				rsp_byte <= {grp != 3'd0, cur_ext[grp*7 +: 7]};   // msb marks more to come
			end
		end
		if (state == E_LEN) begin
			rsp_len <= len;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= E_IDLE;
			nparams <= '0;
			pidx <= '0;
			grp <= '0;
			len <= '0;
			rsp_valid <= 1'b0;
			rsp_len_valid <= 1'b0;
			credits <= CREDIT_BITS'(SEND_CREDITS);
		end else begin
			rsp_valid <= send_ok;
			rsp_len_valid <= 1'b0;
			credits <= credits + CREDIT_BITS'(rsp_credit) - CREDIT_BITS'(send_ok);
			case (state)
			E_IDLE: begin
				if (take_param) begin
					nparams <= nparams + 1'b1;
				end
				if (flush) begin
					len <= '0;
					state <= E_ID;
				end
			end
			E_ID: begin
				if (send_ok) begin
					len <= len + 8'd1;
					pidx <= '0;
					grp <= vlq_len(params[0]) - 3'd1;
					state <= (nparams == '0) ? E_LEN : E_PARAM;
				end
			end
			E_PARAM: begin
				if (send_ok) begin
					len <= len + 8'd1;
					if (grp != 3'd0) begin
						grp <= grp - 3'd1;
					end else if (last_param) begin
						state <= E_LEN;
					end else begin
						pidx <= pidx + 1'b1;
						grp <= vlq_len(params[pidx + 1'b1]) - 3'd1;
					end
				end
			end
			E_LEN: begin
				rsp_len_valid <= 1'b1;
				nparams <= '0;
				state <= E_IDLE;
			end
			default: state <= E_IDLE;
			endcase
		end
	end

	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= SEND_CREDITS);

endmodule

/* system_unit.sv */
`timescale 1ns/1ps

module system_unit import cmd_pkg::*; #(
	parameter arg_t VERSION = 0
) (
	input logic clk,
	input logic rst_n,
	input logic [63:0] systime,
	unit_bus_if.unit bus,
	output logic shutdown
);

	logic active;
	logic [1:0] step;
	logic [1:0] last_step;             // step that ends the command
	logic [63:0] time_snap;
	arg_t step_data;

	assign bus.arg_advance = 1'b0;     // no command here takes arguments

	always_comb begin
		case (bus.cmd)
		CMD_GET_VERSION: last_step = 2'd1;
		CMD_GET_TIME:    last_step = 2'd2;
		default:         last_step = 2'd0;
		endcase
	end

	always_comb begin
		step_data = '0;
		case (bus.cmd)
		CMD_GET_VERSION: begin
			step_data = (step == 2'd0) ? VERSION : arg_t'(RSP_GET_VERSION);
		end
		CMD_GET_TIME: begin
			case (step)
			2'd0:    step_data = time_snap[31:0];     // low word first
			2'd1:    step_data = time_snap[63:32];
			default: step_data = arg_t'(RSP_GET_TIME);
			endcase
		end
		default: step_data = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (bus.cmd_ready) begin
			time_snap <= systime;
		end
		bus.param_data <= step_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			step <= '0;
			bus.param_write <= 1'b0;
			bus.cmd_done <= 1'b0;
			shutdown <= 1'b0;
		end else begin
			bus.param_write <= 1'b0;
			bus.cmd_done <= 1'b0;
			if (bus.cmd_ready) begin
				active <= 1'b1;
				step <= '0;
			end else if (active) begin
				step <= step + 2'd1;
				if (step == last_step) begin
					active <= 1'b0;
					bus.cmd_done <= 1'b1;
					if (bus.cmd == CMD_SHUTDOWN) begin
						shutdown <= 1'b1;       // sticky until reset
					end
				end else begin
					bus.param_write <= 1'b1;
				end
			end
		end
	end

endmodule

/* gpio_unit.sv */
`timescale 1ns/1ps

module gpio_unit import cmd_pkg::*; #(
	parameter int NGPIO = 4
) (
	input logic clk,
	input logic rst_n,
	unit_bus_if.unit bus,
	input logic shutdown,
	output logic [NGPIO-1:0] gpio
);

	localparam int CH_BITS = (NGPIO > 1) ? $clog2(NGPIO) : 1;

	logic active;
	logic [1:0] step;
	logic is_set;
	logic is_cfg;
	logic chan_ok;
	logic [CH_BITS-1:0] ch;
	logic [NGPIO-1:0] dflt;            // value taken on shutdown
	arg_t chan;
	arg_t value;

	assign is_set = (bus.cmd == CMD_SET_DIGITAL_OUT);
	assign is_cfg = (bus.cmd == CMD_CONFIG_DIGITAL_OUT);
	assign chan_ok = ($unsigned(chan) < NGPIO) && !shutdown;
	assign ch = chan[CH_BITS-1:0];
	assign bus.param_write = 1'b0;
	assign bus.param_data = '0;

	always_ff @(posedge clk) begin
		if (bus.cmd_ready) begin
			chan <= bus.arg_data;
		end
		if (active && step == 2'd1) begin
			value <= bus.arg_data;
		end
	end

	// advance is issued ahead so the arguments arrive on consecutive steps
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			step <= '0;
			bus.arg_advance <= 1'b0;
			bus.cmd_done <= 1'b0;
			gpio <= '0;
			dflt <= '0;
		end else begin
			bus.arg_advance <= 1'b0;
			bus.cmd_done <= 1'b0;
			if (bus.cmd_ready) begin
				active <= 1'b1;
				step <= '0;
				bus.arg_advance <= is_set | is_cfg;
			end else if (active) begin
				step <= step + 2'd1;
				case (step)
				2'd0: begin
					bus.arg_advance <= is_cfg;
					if (!is_set && !is_cfg) begin
						active <= 1'b0;
						bus.cmd_done <= 1'b1;
					end
				end
				2'd1: begin
					if (is_set) begin
						if (chan_ok) begin
							gpio[ch] <= bus.arg_data[0];
						end
						active <= 1'b0;
						bus.cmd_done <= 1'b1;
					end
				end
				default: begin
					if (chan_ok) begin
						gpio[ch] <= value[0];
						dflt[ch] <= bus.arg_data[0];
					end
					active <= 1'b0;
					bus.cmd_done <= 1'b1;
				end
				endcase
			end
			if (shutdown) begin
				gpio <= dflt;
			end
		end
	end

endmodule

/* cmd_dispatch.sv */
`timescale 1ns/1ps

module cmd_dispatch import cmd_pkg::*; #(
	parameter int NGPIO = 4,
	parameter arg_t VERSION = 0,
	parameter int SEND_CREDITS = 4
) (
	input logic clk,
	input logic rst_n,
	input logic [7:0] msg_data,
	input logic msg_ready,
	output logic msg_rd_en,
	output logic [7:0] rsp_byte,
	output logic rsp_valid,
	input logic rsp_credit,
	output logic [7:0] rsp_len,
	output logic rsp_len_valid,
	input logic [63:0] systime,
	output logic [NGPIO-1:0] gpio
);

	logic dec_rd_en;
	logic cmd_rd_en;
	logic parse_start;
	logic parse_done;
	logic [2:0] nargs;
	logic [ARG_IDX_BITS-1:0] arg_idx;
	arg_t arg_word;
	arg_t push_data;
	logic param_push;
	logic id_push;
	logic flush;
	logic enc_busy;
	logic shutdown;

	unit_bus_if sys_bus ();
	unit_bus_if gpio_bus ();

	assign msg_rd_en = dec_rd_en | cmd_rd_en;   // command byte and argument bytes

	vlq_decoder i_vlq_decoder (
		.clk(clk),
		.rst_n(rst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.msg_rd_en(dec_rd_en),
		.parse_start(parse_start),
		.nargs(nargs),
		.parse_done(parse_done),
		.arg_idx(arg_idx),
		.arg_word(arg_word)
	);

	cmd_sequencer i_cmd_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.cmd_rd_en(cmd_rd_en),
		.parse_start(parse_start),
		.nargs(nargs),
		.parse_done(parse_done),
		.arg_idx(arg_idx),
		.arg_word(arg_word),
		.sys_bus(sys_bus.seq),
		.gpio_bus(gpio_bus.seq),
		.param_push(param_push),
		.id_push(id_push),
		.push_data(push_data),
		.flush(flush),
		.enc_busy(enc_busy)
	);

	vlq_encoder #(
		.SEND_CREDITS(SEND_CREDITS)
	) i_vlq_encoder (
		.clk(clk),
		.rst_n(rst_n),
		.param_push(param_push),
		.id_push(id_push),
		.push_data(push_data),
		.flush(flush),
		.busy(enc_busy),
		.rsp_byte(rsp_byte),
		.rsp_valid(rsp_valid),
		.rsp_credit(rsp_credit),
		.rsp_len(rsp_len),
		.rsp_len_valid(rsp_len_valid)
	);

	system_unit #(
		.VERSION(VERSION)
	) i_system_unit (
		.clk(clk),
		.rst_n(rst_n),
		.systime(systime),
		.bus(sys_bus.unit),
		.shutdown(shutdown)
	);

	gpio_unit #(
		.NGPIO(NGPIO)
	) i_gpio_unit (
		.clk(clk),
		.rst_n(rst_n),
		.bus(gpio_bus.unit),
		.shutdown(shutdown),
		.gpio(gpio)
	);

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);   // released away from the sampling edge
		rst_n = 1'b1;
	end

endmodule

/* tb_cmd_dispatch.sv */
`timescale 1ns/1ps

module tb_cmd_dispatch import cmd_pkg::*; ();

	localparam int NGPIO = 4;
	localparam arg_t VERSION = -123456789;
	localparam int SEND_CREDITS = 4;
	localparam int TIMEOUT = 2000;     // cycles allowed per wait
	localparam int SETTLE = 8;         // last argument byte to unit done, with margin
	localparam int QUIET = 40;         // cycles watched for a stray response

	logic clk;
	logic rst_n;
	logic [7:0] msg_data = 8'h00;
	logic msg_ready = 1'b0;
	logic msg_rd_en;
	logic [7:0] rsp_byte;
	logic rsp_valid;
	logic rsp_credit = 1'b0;
	logic [7:0] rsp_len;
	logic rsp_len_valid;
	logic [63:0] systime;
	logic [NGPIO-1:0] gpio;

	logic [7:0] rx_q [$];              // host receive queue
	logic [7:0] exp_q [$];             // expected response bytes
	logic [7:0] exp_len_q [$];
	logic [NGPIO-1:0] m_gpio;
	logic [NGPIO-1:0] m_dflt;
	logic m_shut;
	logic hold_credits;
	logic rd_prev = 1'b0;              // msg_rd_en at the previous falling edge
	logic [31:0] stim_lfsr = 32'd82052;
	logic [31:0] credit_lfsr = 32'd82052;
	arg_t bounds [18];
	int bytes_rcvd = 0;
	int credits_seen = 0;
	int lens_rcvd = 0;
	int credits_out = 0;
	int credit_wait = 0;
	int checks = 0;
	int errors = 0;
	int test_err0 = 0;
	int test_num = 0;

	tb_clock #(
		.PERIOD(20),
		.RESET_CYCLES(10)
	) i_tb_clock (
		.clk(clk),
		.rst_n(rst_n)
	);

	cmd_dispatch #(
		.NGPIO(NGPIO),
		.VERSION(VERSION),
		.SEND_CREDITS(SEND_CREDITS)
	) i_cmd_dispatch (
		.clk(clk),
		.rst_n(rst_n),
		.msg_data(msg_data),
		.msg_ready(msg_ready),
		.msg_rd_en(msg_rd_en),
		.rsp_byte(rsp_byte),
		.rsp_valid(rsp_valid),
		.rsp_credit(rsp_credit),
		.rsp_len(rsp_len),
		.rsp_len_valid(rsp_len_valid),
		.systime(systime),
		.gpio(gpio)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// galois form of x^32 + x^22 + x^2 + x + 1
		if (s[0]) begin
			return (s >> 1) ^ 32'h8020_0003;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			r = {r[30:0], stim_lfsr[0]};
		end
		return r;
	endfunction

	function automatic int vlq_count(input arg_t v);
		longint lim;
		for (int n = 1; n < 5; n++) begin
			lim = 64'sd32 << (7 * (n - 1));     // one byte spans -32 up to 95
			if (longint'(v) >= -lim && longint'(v) < 3 * lim) begin
				return n;
			end
		end
		return 5;
	endfunction

	function automatic logic [7:0] vlq_byte(input arg_t v, input int n, input int k);
		logic more;
		arg_t grp;
		more = (k < n - 1);
		grp = v >>> (7 * (n - 1 - k));      // most significant group first
		return {more, grp[6:0]};
	endfunction

	function automatic int add_vlq(input arg_t v, input logic to_rx);
		int n;
		n = vlq_count(v);
		for (int k = 0; k < n; k++) begin
			if (to_rx) begin
				rx_q.push_back(vlq_byte(v, n, k));
			end else begin
				exp_q.push_back(vlq_byte(v, n, k));
			end
		end
		return n;
	endfunction

	// expected response bytes and gpio state, returns the response length
	function automatic int ref_cmd(input logic [7:0] id, input arg_t a0, input arg_t a1,
		input arg_t a2);
		int len;
		logic ch_ok;
		len = 0;
		ch_ok = !m_shut && a0 >= 0 && a0 < NGPIO;
		if (id == 8'(CMD_GET_VERSION)) begin
			exp_q.push_back(8'(RSP_GET_VERSION));
			len = 1 + add_vlq(VERSION, 1'b0);
		end else if (id == 8'(CMD_GET_TIME)) begin
			exp_q.push_back(8'(RSP_GET_TIME));
			len = 1 + add_vlq(systime[31:0], 1'b0);
			len = len + add_vlq(systime[63:32], 1'b0);
		end else if (id == 8'(CMD_CONFIG_DIGITAL_OUT) && ch_ok) begin
			m_gpio[a0] = a1[0];
			m_dflt[a0] = a2[0];
		end else if (id == 8'(CMD_SET_DIGITAL_OUT) && ch_ok) begin
			m_gpio[a0] = a1[0];
		end else if (id == 8'(CMD_SHUTDOWN)) begin
			m_shut = 1'b1;
		end
		if (m_shut) begin
			m_gpio = m_dflt;
		end
		if (len != 0) begin
			exp_len_q.push_back(8'(len));
		end
		return len;
	endfunction

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail rsp_byte: got 0x%02h, expected 0x%02h", got, exp);
		end
	endtask

	task automatic check_len(input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail rsp_len: got 0x%02h, expected 0x%02h", got, exp);
		end
	endtask

	task automatic check_gpio(input logic [NGPIO-1:0] got, input logic [NGPIO-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail gpio: got 0x%0h, expected 0x%0h", got, exp);
		end
	endtask

	// receive queue model, a byte leaves on msg_rd_en
	always @(negedge clk) begin
		if (rst_n && msg_rd_en) begin
			if (rd_prev) begin
				errors++;
				$display("msg_rd_en was high on two consecutive cycles");
			end
			if (rx_q.size() == 0) begin
				errors++;
				$display("msg_rd_en while the receive queue was empty");
			end else begin
				rx_q.delete(0);
			end
		end
		rd_prev = rst_n && msg_rd_en;
		msg_ready <= (rx_q.size() > 0);
		msg_data <= (rx_q.size() > 0) ? rx_q[0] : 8'h00;
	end

	// monitor and compare
	always @(negedge clk) begin
		if (rst_n) begin
			if (rsp_valid) begin
				if (bytes_rcvd + 1 > credits_seen + SEND_CREDITS) begin
					errors++;
					$display("more than %0d response bytes outstanding", SEND_CREDITS);
				end
				if (exp_q.size() == 0) begin
					errors++;
					$display("unexpected response byte 0x%02h", rsp_byte);
				end else begin
					check_byte(rsp_byte, exp_q.pop_front());
				end
				bytes_rcvd <= bytes_rcvd + 1;
			end
			if (rsp_len_valid) begin
				if (exp_len_q.size() == 0) begin
					errors++;
					$display("unexpected response length 0x%02h", rsp_len);
				end else begin
					check_len(rsp_len, exp_len_q.pop_front());
				end
				lens_rcvd <= lens_rcvd + 1;
			end
			if (rsp_credit) begin
				credits_seen <= credits_seen + 1;
			end
		end
	end

	// credit return after 0 to 3 idle cycles
	always @(negedge clk) begin : credit_ret
		int delay;
		rsp_credit <= 1'b0;
		if (rst_n && !hold_credits) begin
			if (credit_wait > 0) begin
				credit_wait <= credit_wait - 1;
			end else if (credits_out < bytes_rcvd) begin
				rsp_credit <= 1'b1;
				credits_out <= credits_out + 1;
				delay = 0;
				for (int i = 0; i < 2; i++) begin
					credit_lfsr = lfsr_next(credit_lfsr);
					delay = delay * 2 + int'(credit_lfsr[0]);
				end
				credit_wait <= delay;
			end
		end
	end

	task automatic set_time(input logic [63:0] t);
		@(negedge clk);
		systime = t;
	endtask

	task automatic wait_len(input int target);
		int n;
		n = 0;
		while (lens_rcvd < target && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (lens_rcvd < target) begin
			errors++;
			$display("timeout waiting for the response length");
		end
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (rx_q.size() > 0 && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (rx_q.size() > 0) begin
			errors++;
			$display("timeout, %0d command bytes were never read", rx_q.size());
		end
		repeat (SETTLE) @(posedge clk);
	endtask

	task automatic issue_cmd(input logic [7:0] id, input int nargs, input arg_t a0,
		input arg_t a1, input arg_t a2, output int len);
		@(posedge clk);
		len = ref_cmd(id, a0, a1, a2);
		rx_q.push_back(id);
		if (nargs > 0) void'(add_vlq(a0, 1'b1));
		if (nargs > 1) void'(add_vlq(a1, 1'b1));
		if (nargs > 2) void'(add_vlq(a2, 1'b1));
	endtask

	task automatic run_cmd(input logic [7:0] id, input int nargs, input arg_t a0,
		input arg_t a1, input arg_t a2);
		int len;
		int target;
		target = lens_rcvd + 1;
		issue_cmd(id, nargs, a0, a1, a2, len);
		if (len != 0) begin
			wait_len(target);
		end else begin
			wait_idle();
		end
		@(negedge clk);
		check_gpio(gpio, m_gpio);
	endtask

	task automatic end_test(input string name);
		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected response bytes never arrived", exp_q.size());
			exp_q.delete();
		end
		test_num++;
		$display("test %0d %s: %s (%0d errors)", test_num, name,
			(errors == test_err0) ? "ok" : "errors", errors - test_err0);
		test_err0 = errors;
	endtask

	initial begin : main
		int len;
		int n;
		int b0;
		int l0;
		arg_t ch;
		arg_t v;
		arg_t d;
		logic [31:0] lo;
		logic [31:0] hi;
		systime = '0;
		m_gpio = '0;
		m_dflt = '0;
		m_shut = 1'b0;
		hold_credits = 1'b0;
		bounds = '{95, 96, -32, -33, 12287, 12288, -4096, -4097, 1572863, 1572864,
			-524288, -524289, 201326591, 201326592, -67108864, -67108865,
			32'h7fff_ffff, 32'h8000_0000};
		n = 0;
		while (!rst_n && n < 100) begin
			@(posedge clk);
			n++;
		end
		if (!rst_n) begin
			errors++;
			$display("timeout waiting for reset release");
		end

		run_cmd(8'(CMD_GET_VERSION), 0, 0, 0, 0);
		end_test("get_version");

		for (int i = 0; i < 18; i += 2) begin
			set_time({bounds[i + 1], bounds[i]});   // low word sits at the lower index
			run_cmd(8'(CMD_GET_TIME), 0, 0, 0, 0);
		end
		for (int i = 0; i < 6; i++) begin
			lo = rand_bits(32);
			hi = rand_bits(32);
			set_time({hi, lo});
			run_cmd(8'(CMD_GET_TIME), 0, 0, 0, 0);
		end
		end_test("get_time");

		for (int i = 0; i < 16; i++) begin
			ch = arg_t'(rand_bits(3));            // half of these are out of range
			v = arg_t'(rand_bits(32));
			d = arg_t'(rand_bits(32));
			if (i % 2 == 0) begin
				run_cmd(8'(CMD_CONFIG_DIGITAL_OUT), 3, ch, v, d);
			end else begin
				run_cmd(8'(CMD_SET_DIGITAL_OUT), 2, ch, v, 0);
			end
		end
		run_cmd(8'(CMD_CONFIG_DIGITAL_OUT), 3, -1, 1, 1);
		run_cmd(8'(CMD_SET_DIGITAL_OUT), 2, 2, 12289, 0);
		run_cmd(8'(CMD_SET_DIGITAL_OUT), 2, 1, -4097, 0);
		run_cmd(8'(CMD_SET_DIGITAL_OUT), 2, 3, -33, 0);
		end_test("digital_out");

		n = 0;
		while ((credits_out != bytes_rcvd || credits_seen != credits_out) && n < TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (credits_out != bytes_rcvd || credits_seen != credits_out) begin
			errors++;
			$display("timeout waiting for the outstanding credits to return");
		end
		hold_credits = 1'b1;
		set_time(64'h8000_0001_7fff_fff0);
		b0 = bytes_rcvd;
		l0 = lens_rcvd;
		issue_cmd(8'(CMD_GET_TIME), 0, 0, 0, 0, len);
		repeat (60) @(posedge clk);
		if (bytes_rcvd - b0 != SEND_CREDITS) begin
			errors++;
			$display("%0d response bytes arrived while credits were held, expected %0d",
				bytes_rcvd - b0, SEND_CREDITS);
		end
		if (lens_rcvd != l0) begin
			errors++;
			$display("response completed while credits were held");
		end
		hold_credits = 1'b0;
		wait_len(l0 + 1);
		end_test("back_pressure");

		run_cmd(8'(CMD_CONFIG_DIGITAL_OUT), 3, 0, 1, 0);
		run_cmd(8'(CMD_CONFIG_DIGITAL_OUT), 3, 1, 0, 1);
		run_cmd(8'(CMD_CONFIG_DIGITAL_OUT), 3, 2, 1, 1);
		run_cmd(8'(CMD_CONFIG_DIGITAL_OUT), 3, 3, 0, 0);
		run_cmd(8'(CMD_SHUTDOWN), 0, 0, 0, 0);
		run_cmd(8'(CMD_SET_DIGITAL_OUT), 2, 3, 1, 0);
		run_cmd(8'(CMD_CONFIG_DIGITAL_OUT), 3, 0, 1, 1);
		run_cmd(8'(CMD_GET_VERSION), 0, 0, 0, 0);
		end_test("shutdown");

		b0 = bytes_rcvd;
		l0 = lens_rcvd;
		run_cmd(8'h05, 0, 0, 0, 0);
		run_cmd(8'h25, 0, 0, 0, 0);
		repeat (QUIET) @(posedge clk);
		if (bytes_rcvd != b0 || lens_rcvd != l0) begin
			errors++;
			$display("a response appeared after an unknown command id");
		end
		run_cmd(8'(CMD_GET_VERSION), 0, 0, 0, 0);
		end_test("unknown_id");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* cmd_dispatch.f */
cmd_pkg.sv
unit_bus_if.sv
vlq_decoder.sv
cmd_sequencer.sv
vlq_encoder.sv
system_unit.sv
gpio_unit.sv
cmd_dispatch.sv
tb_clock.sv
tb_cmd_dispatch.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_cmd_dispatch \
	-f cmd_dispatch.f -o sim_tb > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1 && cat sim.log || { cat sim.log; exit 1; }
grep -q "Testbench passed" sim.log && exit 0 || exit 1
